// File: source/synth_consts.svh
// global constants for the MIDI pulse synthesizer and its measurement setup
`ifndef SYNTH_CONSTS_SVH
`define SYNTH_CONSTS_SVH

// ----------------------------------------
// clocking and serial link
// ----------------------------------------
// system clock in Hz, 4 ns period
`define CLK_FREQ      250000000
// serial bit rate, 20 clocks per bit
`define BAUD_RATE     12500000

// ----------------------------------------
// synth configuration
// ----------------------------------------
// channel the synth listens to, zero based
`define MIDI_CHANNEL  0
// clocks per audio sample
`define SAMPLE_DIV    16

// ----------------------------------------
// DAC and density measurement
// ----------------------------------------
// sigma-delta accumulator width, same as the sample width
`define DAC_ACC_W     18
// clocks to wait after the last byte before measuring
`define SETTLE_CLKS   512
// clocks per density measurement window
`define MEAS_CLKS     8192
// allowed deviation of the ones count
`define COUNT_TOL     8

`endif

// File: source/synth_pkg.sv
// shared vector types and state encodings of the synthesizer chain
package synth_pkg;

    // one received serial byte
    typedef logic [7:0] byte_t;

    // midi data value, note / velocity / controller value
    typedef logic [6:0] midi_val_t;

    // midi channel number
    typedef logic [3:0] midi_ch_t;

    // signed audio sample
    typedef logic signed [17:0] sample_t;

    // kind of decoded channel message
    typedef enum logic [1:0] {
        CMD_NOTE_OFF    = 2'd0,
        CMD_NOTE_ON     = 2'd1,
        CMD_CTRL_CHANGE = 2'd2
    } midi_cmd_t;

    // serial receiver FSM
    typedef enum logic [1:0] {
        IDLE  = 2'd0,
        START = 2'd1,
        DATA  = 2'd2,
        STOP  = 2'd3
    } uart_state_t;

    // midi parser FSM
    typedef enum logic [1:0] {
        WAIT_STATUS = 2'd0,
        WAIT_DATA0  = 2'd1,
        WAIT_DATA1  = 2'd2,
        SKIP_SYSEX  = 2'd3
    } dec_state_t;

endpackage

// File: source/midi_msg_if.sv
// decoded midi message link from the decoder to the tone generator
`timescale 1ns/1ps

interface midi_msg_if
    import synth_pkg::*;
();
    // one message per cycle with valid high, no back-pressure
    logic      valid;
    midi_cmd_t cmd;
    // note number or controller number
    midi_val_t data0;
    // velocity or controller value
    midi_val_t data1;

    // decoder side drives everything
    modport dec (output valid, output cmd, output data0, output data1);

    // generator side only listens
    modport gen (input valid, input cmd, input data0, input data1);
endinterface

// File: source/uart_rx.sv
// 8N1 serial receiver, one byte strobe per correctly framed byte
`timescale 1ns/1ps
`include "synth_consts.svh"

module uart_rx
    import synth_pkg::*;
(
    input  logic  clk,
    input  logic  reset,
    input  logic  rx,
    output logic  byte_valid,
    output byte_t byte_data
);
    localparam int CLKS_PER_BIT = `CLK_FREQ / `BAUD_RATE;
    localparam int CNT_W        = $clog2(CLKS_PER_BIT);
    // middle of the start bit, counted from the falling edge
    localparam logic [CNT_W-1:0] HALF_BIT = CNT_W'(CLKS_PER_BIT / 2 - 1);
    // one full bit period, mid-bit to mid-bit
    localparam logic [CNT_W-1:0] FULL_BIT = CNT_W'(CLKS_PER_BIT - 1);

    logic             rx_meta;
    logic             rx_sync;
    logic             rx_prev;
    uart_state_t      state;
    logic [CNT_W-1:0] baud_cnt;
    logic [2:0]       bit_idx;
    byte_t            shift_q;

    // ----------------------------------------
    // input synchroniser and edge history
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            // idle line is high
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
            rx_prev <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
            rx_prev <= rx_sync;
        end
    end

    // ----------------------------------------
    // receive FSM
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= IDLE;
            baud_cnt   <= '0;
            bit_idx    <= '0;
            byte_valid <= 1'b0;
        end else begin
            byte_valid <= 1'b0;
            baud_cnt   <= baud_cnt + 1'b1;
            case (state)
                IDLE: begin
                    baud_cnt <= '0;
                    // falling edge marks the start bit
                    if (rx_prev && !rx_sync) begin
                        state <= START;
                    end
                end
                START: begin
                    if (baud_cnt == HALF_BIT) begin
                        baud_cnt <= '0;
                        bit_idx  <= '0;
                        // glitch, back to idle
                        state    <= rx_sync ? IDLE : DATA;
                    end
                end
                DATA: begin
                    if (baud_cnt == FULL_BIT) begin
                        baud_cnt <= '0;
                        bit_idx  <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            state <= STOP;
                        end
                    end
                end
                STOP: begin
                    if (baud_cnt == FULL_BIT) begin
                        // low stop bit is a framing error, byte dropped
                        byte_valid <= rx_sync;
                        state      <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // lsb first shift register and output byte
    always_ff @(posedge clk) begin
        if (state == DATA && baud_cnt == FULL_BIT) begin
            shift_q <= {rx_sync, shift_q[7:1]};
        end
        if (state == STOP && baud_cnt == FULL_BIT) begin
            byte_data <= shift_q;
        end
    end

endmodule

// File: source/midi_decoder.sv
// midi byte parser with running status, channel filter and real-time skip
`timescale 1ns/1ps
`include "synth_consts.svh"

module midi_decoder
    import synth_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       byte_valid,
    input  byte_t      byte_data,
    midi_msg_if.dec    msg
);
    dec_state_t state;
    // upper status nibble without the top bit, 0 = note off .. 6 = pitch bend
    logic [2:0] stat_kind;
    midi_ch_t   stat_ch;
    midi_val_t  data0_q;

    logic is_status;
    logic is_realtime;
    logic two_bytes;
    logic ch_match;
    logic wanted;
    logic emit;

    // ----------------------------------------
    // byte classification
    // ----------------------------------------
    assign is_status   = byte_data[7];
    // F8..FF may show up anywhere
    assign is_realtime = (byte_data[7:3] == 5'b11111);
    // program change and channel pressure carry one data byte
    assign two_bytes   = (stat_kind != 3'd4) && (stat_kind != 3'd5);
    assign ch_match    = (stat_ch == midi_ch_t'(`MIDI_CHANNEL));
    // note off, note on, control change
    assign wanted      = (stat_kind == 3'd0) || (stat_kind == 3'd1) || (stat_kind == 3'd3);
    // second data byte of a wanted message on our channel
    assign emit        = byte_valid && !is_status && (state == WAIT_DATA1)
                         && ch_match && wanted;

    // ----------------------------------------
    // parser FSM
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= WAIT_STATUS;
            stat_kind <= '0;
            stat_ch   <= '0;
            msg.valid <= 1'b0;
        end else begin
            msg.valid <= emit;
            // real-time bytes leave the state untouched
            if (byte_valid && !is_realtime) begin
                if (is_status) begin
                    if (byte_data == 8'hF0) begin
                        state <= SKIP_SYSEX;
                    end else if (byte_data[7:4] == 4'hF) begin
                        // system common, also F7 end of sysex
                        // running status is lost here
                        state <= WAIT_STATUS;
                    end else begin
                        stat_kind <= byte_data[6:4];
                        stat_ch   <= byte_data[3:0];
                        state     <= WAIT_DATA0;
                    end
                end else begin
                    case (state)
                        WAIT_DATA0: begin
                            // one byte messages complete here, nothing reported
                            if (two_bytes) begin
                                state <= WAIT_DATA1;
                            end
                        end
                        // message done, keep status for running status
                        WAIT_DATA1: state <= WAIT_DATA0;
                        // stray data or sysex payload
                        default: state <= state;
                    endcase
                end
            end
        end
    end

    // ----------------------------------------
    // data capture and message payload
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (byte_valid && !is_status && state == WAIT_DATA0) begin
            data0_q <= byte_data[6:0];
        end
        if (emit) begin
            msg.data0 <= data0_q;
            msg.data1 <= byte_data[6:0];
            case (stat_kind)
                // velocity 0 note on counts as note off
                3'd1:    msg.cmd <= (byte_data[6:0] == 7'd0) ? CMD_NOTE_OFF : CMD_NOTE_ON;
                3'd3:    msg.cmd <= CMD_CTRL_CHANGE;
                default: msg.cmd <= CMD_NOTE_OFF;
            endcase
        end
    end

endmodule

// File: source/pulse_gen.sv
// monophonic pulse tone generator with sample tick and pan-weighted stereo levels
`timescale 1ns/1ps
`include "synth_consts.svh"

module pulse_gen
    import synth_pkg::*;
(
    input  logic    clk,
    input  logic    reset,
    midi_msg_if.gen msg,
    output logic    sample_valid,
    output sample_t sample_l,
    output sample_t sample_r
);
    localparam int TICK_W = $clog2(`SAMPLE_DIV);
    localparam logic [TICK_W-1:0] TICK_LAST = TICK_W'(`SAMPLE_DIV - 1);
    // half-period counter width in samples
    localparam int HP_W = 13;
    // pan controller number
    localparam midi_val_t CC_PAN = 7'd10;

    logic [TICK_W-1:0] tick_cnt;
    logic              tick;
    logic              playing;
    midi_val_t         note;
    midi_val_t         velocity;
    midi_val_t         pan;
    logic [3:0]        semitone;
    logic [3:0]        octave;
    logic [HP_W-1:0]   base_hp;
    logic [HP_W-1:0]   half_period;
    logic [HP_W-1:0]   phase_cnt;
    logic              pulse_hi;
    logic [13:0]       prod_l;
    logic [13:0]       prod_r;

    // ----------------------------------------
    // sample-rate tick
    // ----------------------------------------
    assign tick = (tick_cnt == TICK_LAST);

    always_ff @(posedge clk) begin
        if (reset) begin
            tick_cnt     <= '0;
            sample_valid <= 1'b0;
        end else begin
            tick_cnt     <= tick ? '0 : tick_cnt + 1'b1;
            sample_valid <= tick;
        end
    end

    // ----------------------------------------
    // note and pan state
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            playing  <= 1'b0;
            note     <= '0;
            velocity <= '0;
            pan      <= 7'd64;
        end else if (msg.valid) begin
            case (msg.cmd)
                CMD_NOTE_ON: begin
                    // last note wins
                    playing  <= 1'b1;
                    note     <= msg.data0;
                    velocity <= msg.data1;
                end
                CMD_NOTE_OFF: begin
                    // only the sounding note can stop it
                    if (msg.data0 == note) begin
                        playing <= 1'b0;
                    end
                end
                CMD_CTRL_CHANGE: begin
                    if (msg.data0 == CC_PAN) begin
                        pan <= msg.data1;
                    end
                end
                default: playing <= playing;
            endcase
        end
    end

    // ----------------------------------------
    // pitch lookup
    // ----------------------------------------
    assign semitone = 4'(note % 7'd12);
    assign octave   = 4'(note / 7'd12);

    // octave zero half-periods in samples
    // C sits on 4096 so every C is a power-of-two period
    always_comb begin
        case (semitone)
            4'd0:    base_hp = 13'd4096;
            4'd1:    base_hp = 13'd3866;
            4'd2:    base_hp = 13'd3649;
            4'd3:    base_hp = 13'd3444;
            4'd4:    base_hp = 13'd3251;
            4'd5:    base_hp = 13'd3069;
            4'd6:    base_hp = 13'd2896;
            4'd7:    base_hp = 13'd2734;
            4'd8:    base_hp = 13'd2580;
            4'd9:    base_hp = 13'd2435;
            4'd10:   base_hp = 13'd2299;
            default: base_hp = 13'd2170;
        endcase
    end

    // each octave halves the period, at least 2 samples at the top
    assign half_period = base_hp >> octave;

    // ----------------------------------------
    // pulse oscillator, 50 % duty
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            phase_cnt <= '0;
            pulse_hi  <= 1'b0;
        end else if (tick) begin
            // >= so a shorter new period cannot overrun
            if (phase_cnt >= half_period - HP_W'(1)) begin
                phase_cnt <= '0;
                pulse_hi  <= ~pulse_hi;
            end else begin
                phase_cnt <= phase_cnt + 1'b1;
            end
        end
    end

    // ----------------------------------------
    // stereo levels
    // ----------------------------------------
    // velocity x pan weight, 14 bit products
    assign prod_l = velocity * (7'd127 - pan);
    assign prod_r = velocity * pan;

    // x8 keeps the peak below 2^17, always positive
    always_ff @(posedge clk) begin
        if (tick) begin
            sample_l <= (playing && pulse_hi) ? sample_t'({1'b0, prod_l, 3'b000}) : '0;
            sample_r <= (playing && pulse_hi) ? sample_t'({1'b0, prod_r, 3'b000}) : '0;
        end
    end

endmodule

// File: source/stereo_dac_output.sv
// stereo first-order sigma-delta modulator, one output bit per clock and channel
`timescale 1ns/1ps
`include "synth_consts.svh"

module stereo_dac_output
    import synth_pkg::*;
(
    input  logic    clk,
    input  logic    reset,
    input  logic    sample_valid,
    input  sample_t sample_l,
    input  sample_t sample_r,
    output logic    dac_out_l,
    output logic    dac_out_r
);
    localparam int W = `DAC_ACC_W;
    // offset binary midpoint, sample 0
    localparam logic [W-1:0] MID = W'(1) << (W - 1);

    // index 0 left, 1 right
    sample_t        samp_in [2];
    logic [W-1:0]   held    [2];
    logic [W-1:0]   acc     [2];
    logic [1:0]     carry_q;

    assign samp_in[0] = sample_l;
    assign samp_in[1] = sample_r;

    // ----------------------------------------
    // per channel modulator
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 2; i++) begin
                // start from silence, half density
                held[i] <= MID;
                acc[i]  <= '0;
            end
            carry_q <= '0;
        end else begin
            for (int i = 0; i < 2; i++) begin
                // flip the sign bit for offset binary
                if (sample_valid) begin
                    held[i] <= W'(samp_in[i]) ^ MID;
                end
                // carry out is the 1-bit stream
                {carry_q[i], acc[i]} <= {1'b0, acc[i]} + {1'b0, held[i]};
            end
        end
    end

    assign dac_out_l = carry_q[0];
    assign dac_out_r = carry_q[1];

endmodule

// File: source/midi_synth_top.sv
// synthesizer top level, serial midi in, stereo 1-bit DAC streams out
`timescale 1ns/1ps

module midi_synth_top
    import synth_pkg::*;
(
    input  logic clk,
    input  logic reset,
    input  logic rx,
    output logic dac_out_l,
    output logic dac_out_r
);
    // serial receiver to parser
    logic    byte_valid;
    byte_t   byte_data;

    // generator to DAC
    logic    sample_valid;
    sample_t sample_l;
    sample_t sample_r;

    // decoded message bus
    midi_msg_if msg_bus ();

    uart_rx uart_rx_i (
        .clk        (clk       ),
        .reset      (reset     ),
        .rx         (rx        ),
        .byte_valid (byte_valid),
        .byte_data  (byte_data )
    );

    midi_decoder midi_decoder_i (
        .clk        (clk       ),
        .reset      (reset     ),
        .byte_valid (byte_valid),
        .byte_data  (byte_data ),
        .msg        (msg_bus   )
    );

    pulse_gen pulse_gen_i (
        .clk          (clk         ),
        .reset        (reset       ),
        .msg          (msg_bus     ),
        .sample_valid (sample_valid),
        .sample_l     (sample_l    ),
        .sample_r     (sample_r    )
    );

    stereo_dac_output stereo_dac_output_i (
        .clk          (clk         ),
        .reset        (reset       ),
        .sample_valid (sample_valid),
        .sample_l     (sample_l    ),
        .sample_r     (sample_r    ),
        .dac_out_l    (dac_out_l   ),
        .dac_out_r    (dac_out_r   )
    );

endmodule

// File: testbench/midi_synth_assert.sv
// concurrent checks on the decoded message bus and the sample tick
`timescale 1ns/1ps
`include "synth_consts.svh"

module midi_synth_assert
    import synth_pkg::*;
(
    input logic      clk,
    input logic      reset,
    input logic      msg_valid,
    input midi_cmd_t msg_cmd,
    input logic      sample_valid
);
    // idle cycles between two sample ticks
    localparam int TICK_GAP = `SAMPLE_DIV - 1;

    int fail_cnt;

    initial begin
        fail_cnt = 0;
    end

    // a message never lasts two cycles
    msg_single_cycle: assert property (
        @(posedge clk) disable iff (reset) msg_valid |=> !msg_valid
    ) else begin
        $error("decoder valid high in two consecutive cycles");
        fail_cnt++;
    end

    msg_cmd_known: assert property (
        @(posedge clk) disable iff (reset) msg_valid |-> !$isunknown(msg_cmd)
    ) else begin
        $error("decoder valid with unknown cmd");
        fail_cnt++;
    end

    // tick period is exactly SAMPLE_DIV clocks
    sample_tick_period: assert property (
        @(posedge clk) disable iff (reset)
        sample_valid |=> (!sample_valid) [*TICK_GAP] ##1 sample_valid
    ) else begin
        $error("sample_valid spacing differs from the sample divider");
        fail_cnt++;
    end

endmodule

// File: testbench/midi_synth_checker.sv
// density checker, counts ones on both DAC streams and compares with expected levels
`timescale 1ns/1ps
`include "synth_consts.svh"

module midi_synth_checker (
    input  logic  clk,
    input  logic  reset,
    input  logic  dac_out_l,
    input  logic  dac_out_r,
    input  logic  start,
    input  string test_name,
    input  int    level_l,
    input  int    level_r,
    output int    checks_done,
    output int    pass_count,
    output int    fail_count
);
    // offset binary midpoint of the modulator
    localparam longint MID = longint'(1) << (`DAC_ACC_W - 1);

    // 50 % pulse averages half its level
    function automatic int expected_count(input int level);
        longint avg;
        avg = longint'(level / 2) + MID;
        return int'((avg * `MEAS_CLKS) / (2 * MID));
    endfunction

    task automatic compare_side(input string name, input string side,
                                input int exp_cnt, input int act_cnt, output bit ok);
        int diff;
        diff = act_cnt - exp_cnt;
        ok   = (diff <= `COUNT_TOL) && (diff >= -`COUNT_TOL);
        if (!ok) begin
            $display("MISMATCH %s %s: expected %0d actual %0d", name, side, exp_cnt, act_cnt);
        end
    endtask

    task automatic run_check();
        string name;
        int    exp_l;
        int    exp_r;
        int    ones_l;
        int    ones_r;
        bit    ok_l;
        bit    ok_r;
        name   = test_name;
        exp_l  = expected_count(level_l);
        exp_r  = expected_count(level_r);
        ones_l = 0;
        ones_r = 0;
        // let the chain reach its new level
        repeat (`SETTLE_CLKS) @(posedge clk);
        repeat (`MEAS_CLKS) begin
            @(posedge clk);
            ones_l += int'(dac_out_l);
            ones_r += int'(dac_out_r);
        end
        compare_side(name, "left", exp_l, ones_l, ok_l);
        compare_side(name, "right", exp_r, ones_r, ok_r);
        if (ok_l && ok_r) begin
            pass_count++;
            $display("PASS %s: left %0d right %0d ones", name, ones_l, ones_r);
        end else begin
            fail_count++;
        end
        checks_done++;
    endtask

    initial begin
        checks_done = 0;
        pass_count  = 0;
        fail_count  = 0;
        forever begin
            @(posedge clk);
            if (start && !reset) begin
                run_check();
            end
        end
    end

endmodule

// File: testbench/midi_synth_tb.sv
// testbench top for the midi synth with serial stimulus table, watchdog and verdict
`timescale 1ns/1ps
`include "synth_consts.svh"

module midi_synth_tb
    import synth_pkg::*;
();
    localparam int CLKS_PER_BIT = `CLK_FREQ / `BAUD_RATE;
    localparam int MAX_BYTES    = 6;
    localparam int MAX_ROWS     = 16;
    // worst case clocks per row including settle and measurement
    localparam int ROW_CLKS     = MAX_BYTES * 10 * CLKS_PER_BIT + `SETTLE_CLKS + `MEAS_CLKS;

    logic  clk;
    logic  reset;
    logic  rx;
    logic  dac_out_l;
    logic  dac_out_r;

    // checker handshake
    logic  chk_start;
    string chk_name;
    int    chk_level_l;
    int    chk_level_r;
    int    checks_done;
    int    pass_count;
    int    fail_count;

    // ----------------------------------------
    // stimulus table
    // ----------------------------------------
    string                  row_name  [MAX_ROWS];
    // byte 0 sits in the top byte
    logic [8*MAX_BYTES-1:0] row_bytes [MAX_ROWS];
    int                     row_len   [MAX_ROWS];
    // index of the byte sent with a low stop bit or -1
    int                     row_bad   [MAX_ROWS];
    int                     row_exp_l [MAX_ROWS];
    int                     row_exp_r [MAX_ROWS];
    int                     num_rows;

    // reference tone state
    bit m_playing;
    int m_note;
    int m_vel;
    int m_pan;

    midi_synth_top dut_i (
        .clk       (clk      ),
        .reset     (reset    ),
        .rx        (rx       ),
        .dac_out_l (dac_out_l),
        .dac_out_r (dac_out_r)
    );

    midi_synth_checker chk_i (
        .clk         (clk        ),
        .reset       (reset      ),
        .dac_out_l   (dac_out_l  ),
        .dac_out_r   (dac_out_r  ),
        .start       (chk_start  ),
        .test_name   (chk_name   ),
        .level_l     (chk_level_l),
        .level_r     (chk_level_r),
        .checks_done (checks_done),
        .pass_count  (pass_count ),
        .fail_count  (fail_count )
    );

    // protocol checks on the decoder to generator bus and the sample tick
    bind midi_synth_top midi_synth_assert assert_i (
        .clk          (clk          ),
        .reset        (reset        ),
        .msg_valid    (msg_bus.valid),
        .msg_cmd      (msg_bus.cmd  ),
        .sample_valid (sample_valid )
    );

    // ----------------------------------------
    // reference model of note and pan
    // ----------------------------------------
    task automatic model_note_off(input int n);
        // only the sounding note stops the tone
        if (n == m_note) begin
            m_playing = 1'b0;
        end
    endtask

    task automatic model_note_on(input int n, input int v);
        // zero velocity acts as note off
        if (v == 0) begin
            model_note_off(n);
        end else begin
            m_playing = 1'b1;
            m_note    = n;
            m_vel     = v;
        end
    endtask

    task automatic model_control(input int c, input int v);
        // controller 10 is pan
        if (c == 10) begin
            m_pan = v;
        end
    endtask

    // row takes the expected levels from the model as it stands
    task automatic add_row(input string name, input logic [8*MAX_BYTES-1:0] seq,
                           input int len, input int bad);
        row_name[num_rows]  = name;
        row_bytes[num_rows] = seq;
        row_len[num_rows]   = len;
        row_bad[num_rows]   = bad;
        row_exp_l[num_rows] = m_playing ? m_vel * (127 - m_pan) * 8 : 0;
        row_exp_r[num_rows] = m_playing ? m_vel * m_pan * 8 : 0;
        num_rows++;
    endtask

    task automatic build_table();
        int rv;
        rv        = 1 + ($urandom % 127);
        num_rows  = 0;
        m_playing = 1'b0;
        m_note    = 0;
        m_vel     = 0;
        m_pan     = 64;
        add_row("idle", 48'h0, 0, -1);
        model_note_on(60, 100);
        add_row("note_on_center", 48'h903C64_000000, 3, -1);
        model_note_on(60, rv);
        add_row("note_on_rand_vel", {8'h90, 8'h3C, 1'b0, 7'(rv), 24'h0}, 3, -1);
        model_control(10, 0);
        add_row("pan_hard_left", 48'hB00A00_000000, 3, -1);
        model_control(10, 127);
        add_row("pan_hard_right", 48'hB00A7F_000000, 3, -1);
        model_control(7, 16);
        add_row("other_controller", 48'hB00710_000000, 3, -1);
        model_note_off(62);
        add_row("note_off_other", 48'h803E40_000000, 3, -1);
        model_note_off(60);
        add_row("note_off_match", 48'h803C40_000000, 3, -1);
        model_control(10, 64);
        add_row("pan_back_center", 48'hB00A40_000000, 3, -1);
        model_note_on(48, 80);
        add_row("note_on_low", 48'h903050_000000, 3, -1);
        model_note_on(48, 0);
        add_row("note_on_vel_zero", 48'h903000_000000, 3, -1);
        // second pair rides on running status
        model_note_on(60, 0);
        model_note_on(72, 64);
        add_row("running_status", 48'h903C00_484000, 5, -1);
        model_note_on(60, 48);
        add_row("realtime_between", 48'h3CFE30_F80000, 4, -1);
        // zero velocity on a silent note keeps the sounding one
        model_note_on(72, 0);
        add_row("vel_zero_other_note", 48'h904800_000000, 3, -1);
        // channel 1 traffic leaves the model alone
        add_row("other_channel", 48'h913C00_813C40, 6, -1);
        // status of the note on is lost so the pair decodes as note off
        model_note_off(60);
        model_note_off(72);
        add_row("bad_stop_note_on", 48'h803C00_90487F, 6, 3);
    endtask

    // ----------------------------------------
    // serial driver for 8N1 lsb first
    // ----------------------------------------
    task automatic drive_bit(input logic v);
        @(negedge clk);
        rx = v;
        repeat (CLKS_PER_BIT - 1) @(negedge clk);
    endtask

    task automatic send_byte(input byte_t b, input bit bad_stop);
        int gap;
        gap = CLKS_PER_BIT + $urandom_range(15, 0);
        drive_bit(1'b0);
        for (int k = 0; k < 8; k++) begin
            drive_bit(b[k]);
        end
        drive_bit(!bad_stop);
        // idle high before the next start bit
        @(negedge clk);
        rx = 1'b1;
        repeat (gap - 1) @(negedge clk);
    endtask

    // ----------------------------------------
    // clock and watchdog
    // ----------------------------------------
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        int limit;
        // table is built at time zero
        @(posedge clk);
        limit = num_rows * ROW_CLKS + 1000;
        repeat (limit) @(posedge clk);
        $display("ERROR: the run timed out after %0d clocks without finishing", limit);
        $display("Simulation failed");
        $finish;
    end

    // ----------------------------------------
    // main sequence
    // ----------------------------------------
    initial begin
        void'($urandom(32'hdcdb538e));
        rx          = 1'b1;
        reset       = 1'b1;
        chk_start   = 1'b0;
        chk_name    = "";
        chk_level_l = 0;
        chk_level_r = 0;
        build_table();
        repeat (10) @(negedge clk);
        reset = 1'b0;
        for (int i = 0; i < num_rows; i++) begin
            for (int k = 0; k < row_len[i]; k++) begin
                send_byte(row_bytes[i][8*(MAX_BYTES-1-k) +: 8], k == row_bad[i]);
            end
            @(negedge clk);
            chk_name    = row_name[i];
            chk_level_l = row_exp_l[i];
            chk_level_r = row_exp_r[i];
            chk_start   = 1'b1;
            @(negedge clk);
            chk_start = 1'b0;
            wait (checks_done == i + 1);
        end
        $display("tests run %0d, passed %0d, failed %0d, assertion failures %0d",
                 checks_done, pass_count, fail_count, dut_i.assert_i.fail_cnt);
        if (fail_count == 0 && dut_i.assert_i.fail_cnt == 0 && checks_done == num_rows) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: src.f
+incdir+source
source/synth_pkg.sv
source/midi_msg_if.sv
source/uart_rx.sv
source/midi_decoder.sv
source/pulse_gen.sv
source/stereo_dac_output.sv
source/midi_synth_top.sv
testbench/midi_synth_assert.sv
testbench/midi_synth_checker.sv
testbench/midi_synth_tb.sv

// File: Bender.yml
package:
  name: midi_synth

sources:
  - include_dirs:
      - source
    files:
      - source/synth_pkg.sv
      - source/midi_msg_if.sv
      - source/uart_rx.sv
      - source/midi_decoder.sv
      - source/pulse_gen.sv
      - source/stereo_dac_output.sv
      - source/midi_synth_top.sv
  - target: test
    include_dirs:
      - source
    files:
      - testbench/midi_synth_assert.sv
      - testbench/midi_synth_checker.sv
      - testbench/midi_synth_tb.sv
